// File: sdram_pkg.sv
`default_nettype none

package sdram_pkg;

	localparam int WORD_ADDR_W = 23;	// 32 MB of 32-bit words.
	localparam int HALF_ADDR_W = 24;
	localparam int COL_W = 9;
	localparam int ROW_W = 13;
	localparam int BANK_W = 2;

	localparam int INIT_WAIT_CYCLES = 200;
	localparam int T_RP = 2;
	localparam int T_RCD = 2;
	localparam int T_RFC = 7;
	localparam int CAS_LATENCY = 2;
	localparam int REFRESH_INTERVAL = 390;	// 64 ms / 8192 rows at 50 MHz.
	localparam int COUNT_W = $clog2(INIT_WAIT_CYCLES + 1);
	localparam int REFRESH_W = $clog2(REFRESH_INTERVAL);

	// Burst length 1, sequential, CAS latency 2.
	localparam logic [12:0] MODE_VALUE = 13'b000_0_00_010_0_000;

	// Encoded as {cs_n, ras_n, cas_n, we_n}.
	typedef enum logic [3:0] {
		MODE      = 4'b0000,
		REFRESH   = 4'b0001,
		PRECHARGE = 4'b0010,
		ACTIVE    = 4'b0011,
		WRITE     = 4'b0100,
		READ      = 4'b0101,
		NOP       = 4'b0111
	} sdram_cmd_e;

	typedef struct packed {
		logic [WORD_ADDR_W-1:0] addr;
		logic [31:0]            wdata;
		logic                   wr_en;
		logic [3:0]             bytesel;
	} word_req_t;

	typedef struct packed {
		logic [HALF_ADDR_W-1:0] addr;
		logic [15:0]            wdata;
		logic                   wr_en;
		logic [1:0]             bytesel;
	} half_req_t;

	typedef struct packed {
		sdram_cmd_e        cmd;
		logic [BANK_W-1:0] bank;
		logic [ROW_W-1:0]  addr;
		logic [1:0]        dqm;
		logic [15:0]       dq_out;
		logic              dq_oe;
		logic              cke;
	} sdram_pins_t;

endpackage

`default_nettype wire

// File: sdram_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module sdram_arbiter
	import sdram_pkg::*;
(
	input  wire logic                   clk,
	input  wire logic                   i_reset,
	input  wire logic                   i_ctrl_cs,
	input  wire logic                   i_d_access,
	input  wire logic                   i_d_cs,
	input  wire logic [WORD_ADDR_W-1:0] i_d_addr,
	input  wire logic [31:0]            i_d_wr_val,
	input  wire logic                   i_d_wr_en,
	input  wire logic [3:0]             i_d_bytesel,
	input  wire logic                   i_i_access,
	input  wire logic                   i_i_cs,
	input  wire logic [WORD_ADDR_W-1:0] i_i_addr,
	input  wire logic                   i_req_done,
	input  wire logic [31:0]            i_req_rdata,
	input  wire logic                   i_init_done,
	output logic                        o_d_ack,
	output logic [31:0]                 o_d_data,
	output logic                        o_i_ack,
	output logic [31:0]                 o_i_data,
	output logic                        o_req_valid,
	output word_req_t                   o_req
);

	logic        d_start;
	logic        i_start;
	logic        d_in_progress;
	logic        i_in_progress;
	logic        d_owns;
	logic        ctrl_ack;
	logic [31:0] ctrl_data;

	assign d_start = i_d_access & i_d_cs;
	assign i_start = i_i_access & i_i_cs;
	// A fetch already in the bridge finishes first, so data waits one fetch at most.
	assign d_owns = d_in_progress | (d_start & ~i_in_progress);

	assign o_req_valid = d_owns ? d_start : i_start;
	assign o_req.addr = d_owns ? i_d_addr : i_i_addr;
	assign o_req.wdata = i_d_wr_val;
	assign o_req.wr_en = d_owns & i_d_wr_en;	// Fetches never write.
	assign o_req.bytesel = d_owns ? i_d_bytesel : 4'b1111;

	assign o_d_ack = ctrl_ack | (d_owns & i_req_done);
	assign o_i_ack = ~d_owns & i_req_done;
	assign o_i_data = o_i_ack ? i_req_rdata : 32'b0;

	always_comb begin
		o_d_data = 32'b0;
		if (ctrl_ack)
			o_d_data = ctrl_data;
		else if (d_owns & i_req_done)
			o_d_data = i_req_rdata;
	end

	always_ff @(posedge clk) begin
		if (i_reset) begin
			d_in_progress <= 1'b0;
			i_in_progress <= 1'b0;
		end else if (i_req_done) begin
			d_in_progress <= 1'b0;
			i_in_progress <= 1'b0;
		end else if (o_req_valid) begin
			d_in_progress <= d_owns;
			i_in_progress <= ~d_owns;
		end
	end

	// The held request must not ack twice.
	always_ff @(posedge clk) begin
		if (i_reset)
			ctrl_ack <= 1'b0;
		else
			ctrl_ack <= i_d_access & i_ctrl_cs & ~ctrl_ack;
	end

	always_ff @(posedge clk)
		ctrl_data <= i_d_wr_en ? 32'b0 : {31'b0, i_init_done};

	assert property (@(posedge clk) disable iff (i_reset) !(o_d_ack && o_i_ack));

endmodule

`default_nettype wire

// File: bridge_32_16.sv
`timescale 1ns/1ns
`default_nettype none

module bridge_32_16
	import sdram_pkg::*;
(
	input  wire logic        clk,
	input  wire logic        i_reset,
	input  wire logic        i_req_valid,
	input  wire word_req_t   i_req,
	input  wire logic        i_half_done,
	input  wire logic [15:0] i_half_rdata,
	output logic             o_done,
	output logic [31:0]      o_rdata,
	output logic             o_half_valid,
	output half_req_t        o_half_req
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_LOW,
		S_HIGH
	} state_e;

	state_e      state;
	logic        need_low;
	logic        need_high;
	logic        last_half;
	logic [15:0] low_q;

	assign need_high = |i_req.bytesel[3:2];
	// An empty mask still makes one masked access so the request completes.
	assign need_low = |i_req.bytesel[1:0] | ~need_high;
	assign last_half = (state == S_HIGH) | ((state == S_LOW) & ~need_high);

	assign o_half_valid = state != S_IDLE;
	assign o_half_req.addr = {i_req.addr, state == S_HIGH};
	assign o_half_req.wdata = (state == S_HIGH) ? i_req.wdata[31:16] : i_req.wdata[15:0];
	assign o_half_req.wr_en = i_req.wr_en;
	assign o_half_req.bytesel = (state == S_HIGH) ? i_req.bytesel[3:2] : i_req.bytesel[1:0];

	assign o_done = i_half_done & last_half;

	always_comb begin
		o_rdata = 32'b0;
		if (o_done) begin
			if (state == S_HIGH)
				o_rdata = {i_half_rdata, need_low ? low_q : 16'b0};
			else
				o_rdata = {16'b0, i_half_rdata};
		end
	end

	always_ff @(posedge clk) begin
		if (i_reset) begin
			state <= S_IDLE;
		end else begin
			case (state)
			S_IDLE: begin
				if (i_req_valid)
					state <= need_low ? S_LOW : S_HIGH;
			end
			S_LOW: begin
				if (i_half_done)
					state <= need_high ? S_HIGH : S_IDLE;
			end
			S_HIGH: begin
				if (i_half_done)
					state <= S_IDLE;
			end
			default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
		if (state == S_LOW && i_half_done)
			low_q <= i_half_rdata;	// Held until the high half returns.

	assert property (@(posedge clk) disable iff (i_reset) i_half_done |-> o_half_valid);

endmodule

`default_nettype wire

// File: sdram_controller.sv
`timescale 1ns/1ns
`default_nettype none

module sdram_controller
	import sdram_pkg::*;
(
	input  wire logic        clk,
	input  wire logic        i_reset,
	input  wire logic        i_req_valid,
	input  wire half_req_t   i_req,
	input  wire logic [15:0] i_dq_in,
	output logic             o_done,
	output logic [15:0]      o_rdata,
	output logic             o_init_done,
	output sdram_pins_t      o_pins
);

	typedef enum logic [2:0] {
		S_INIT,
		S_INIT_REFRESH_1,
		S_INIT_REFRESH_2,
		S_INIT_MODE,
		S_IDLE,
		S_ACCESS,
		S_READ_WAIT
	} state_e;

	state_e              state;
	logic [COUNT_W-1:0]  count;
	logic [REFRESH_W-1:0] refresh_timer;
	logic                refresh_due;
	logic                init_done;
	logic                done_q;
	logic [15:0]         rdata_q;
	sdram_pins_t         pins_q;
	logic [COL_W-1:0]    col;
	logic [ROW_W-1:0]    row;
	logic [BANK_W-1:0]   bank;

	assign col = i_req.addr[COL_W-1:0];
	assign row = i_req.addr[COL_W +: ROW_W];
	assign bank = i_req.addr[COL_W + ROW_W +: BANK_W];

	assign o_done = done_q;
	assign o_rdata = rdata_q;
	assign o_init_done = init_done;
	assign o_pins = pins_q;

	// Free running, so refresh spacing does not drift with access waits.
	always_ff @(posedge clk) begin
		if (i_reset || refresh_timer == '0)
			refresh_timer <= REFRESH_W'(REFRESH_INTERVAL - 1);
		else
			refresh_timer <= refresh_timer - 1'b1;
	end

	// Every state first waits out count, then acts once.
	always_ff @(posedge clk) begin
		pins_q.cmd <= NOP;
		pins_q.dq_oe <= 1'b0;
		pins_q.cke <= 1'b1;
		done_q <= 1'b0;
		if (i_reset) begin
			state <= S_INIT;
			count <= COUNT_W'(INIT_WAIT_CYCLES);
			init_done <= 1'b0;
			refresh_due <= 1'b0;
			pins_q.bank <= '0;
			pins_q.addr <= '0;
			pins_q.dqm <= '0;
			pins_q.dq_out <= '0;
		end else begin
			if (count != '0) begin
				count <= count - 1'b1;
			end else begin
				case (state)
				S_INIT: begin
					pins_q.cmd <= PRECHARGE;
					pins_q.addr <= ROW_W'(1 << 10);	// A10 selects all banks.
					state <= S_INIT_REFRESH_1;
					count <= COUNT_W'(T_RP - 1);
				end
				S_INIT_REFRESH_1: begin
					pins_q.cmd <= REFRESH;
					state <= S_INIT_REFRESH_2;
					count <= COUNT_W'(T_RFC - 1);
				end
				S_INIT_REFRESH_2: begin
					pins_q.cmd <= REFRESH;
					state <= S_INIT_MODE;
					count <= COUNT_W'(T_RFC - 1);
				end
				S_INIT_MODE: begin
					pins_q.cmd <= MODE;
					pins_q.bank <= '0;
					pins_q.addr <= MODE_VALUE;
					state <= S_IDLE;
					count <= COUNT_W'(T_RP - 1);
				end
				S_IDLE: begin
					init_done <= 1'b1;
					if (refresh_due) begin
						pins_q.cmd <= REFRESH;
						refresh_due <= 1'b0;
						count <= COUNT_W'(T_RFC - 1);
					end else if (i_req_valid) begin
						pins_q.cmd <= ACTIVE;
						pins_q.bank <= bank;
						pins_q.addr <= row;
						state <= S_ACCESS;
						count <= COUNT_W'(T_RCD - 1);
					end
				end
				S_ACCESS: begin
					pins_q.bank <= bank;
					pins_q.addr <= {2'b00, 1'b1, 1'b0, col};	// A10 sets auto-precharge.
					if (i_req.wr_en) begin
						pins_q.cmd <= WRITE;
						pins_q.dqm <= ~i_req.bytesel;
						pins_q.dq_out <= i_req.wdata;
						pins_q.dq_oe <= 1'b1;
						done_q <= 1'b1;
						state <= S_IDLE;
						count <= COUNT_W'(T_RP);
					end else begin
						pins_q.cmd <= READ;
						pins_q.dqm <= 2'b00;
						state <= S_READ_WAIT;
						count <= COUNT_W'(CAS_LATENCY);
					end
				end
				S_READ_WAIT: begin
					rdata_q <= i_dq_in;	// CAS latency plus one after READ.
					done_q <= 1'b1;
					state <= S_IDLE;
					count <= COUNT_W'(T_RP);
				end
				default: begin
					state <= S_INIT;
					count <= COUNT_W'(INIT_WAIT_CYCLES);
				end
				endcase
			end
			if (refresh_timer == '0)
				refresh_due <= 1'b1;
		end
	end

	assert property (@(posedge clk) disable iff (i_reset) o_done |-> o_init_done);

endmodule

`default_nettype wire

// File: sdram_port.sv
`timescale 1ns/1ns
`default_nettype none

module sdram_port
	import sdram_pkg::*;
(
	input  wire logic                   clk,
	input  wire logic                   i_reset,
	input  wire logic                   i_ctrl_cs,
	input  wire logic                   i_d_access,
	input  wire logic                   i_d_cs,
	input  wire logic [WORD_ADDR_W-1:0] i_d_addr,
	input  wire logic [31:0]            i_d_wr_val,
	input  wire logic                   i_d_wr_en,
	input  wire logic [3:0]             i_d_bytesel,
	input  wire logic                   i_i_access,
	input  wire logic                   i_i_cs,
	input  wire logic [WORD_ADDR_W-1:0] i_i_addr,
	input  wire logic [15:0]            i_dq_in,
	output logic                        o_d_ack,
	output logic [31:0]                 o_d_data,
	output logic                        o_i_ack,
	output logic [31:0]                 o_i_data,
	output sdram_pins_t                 o_sdram
);

	logic        req_valid;
	word_req_t   word_req;
	logic        req_done;
	logic [31:0] req_rdata;
	logic        half_valid;
	half_req_t   half_req;
	logic        half_done;
	logic [15:0] half_rdata;
	logic        init_done;

	sdram_arbiter arbiter_i (
		.clk(clk), .i_reset(i_reset), .i_ctrl_cs(i_ctrl_cs),
		.i_d_access(i_d_access), .i_d_cs(i_d_cs), .i_d_addr(i_d_addr),
		.i_d_wr_val(i_d_wr_val), .i_d_wr_en(i_d_wr_en), .i_d_bytesel(i_d_bytesel),
		.i_i_access(i_i_access), .i_i_cs(i_i_cs), .i_i_addr(i_i_addr),
		.i_req_done(req_done), .i_req_rdata(req_rdata), .i_init_done(init_done),
		.o_d_ack(o_d_ack), .o_d_data(o_d_data), .o_i_ack(o_i_ack), .o_i_data(o_i_data),
		.o_req_valid(req_valid), .o_req(word_req)
	);

	bridge_32_16 bridge_i (
		.clk(clk), .i_reset(i_reset), .i_req_valid(req_valid), .i_req(word_req),
		.i_half_done(half_done), .i_half_rdata(half_rdata),
		.o_done(req_done), .o_rdata(req_rdata),
		.o_half_valid(half_valid), .o_half_req(half_req)
	);

	sdram_controller controller_i (
		.clk(clk), .i_reset(i_reset), .i_req_valid(half_valid), .i_req(half_req),
		.i_dq_in(i_dq_in), .o_done(half_done), .o_rdata(half_rdata),
		.o_init_done(init_done), .o_pins(o_sdram)
	);

endmodule

`default_nettype wire

// File: sdram_model.sv
`timescale 1ns/1ns
`default_nettype none

module sdram_model
	import sdram_pkg::*;
(
	input  wire logic        clk,
	input  wire logic        i_reset,
	input  wire sdram_pins_t i_pins,
	output logic [15:0]      o_dq,
	output int               o_errors,
	output int               o_writes,
	output logic             o_mode_seen
);

	logic [15:0]      mem [int];
	logic [3:0]       bank_open;
	logic [ROW_W-1:0] open_row [4];
	int               gap;
	int               min_gap;
	logic             rd_pend;
	int               rd_addr;
	int               cur_addr;
	logic [15:0]      merged;

	assign cur_addr = int'({i_pins.bank, open_row[i_pins.bank], i_pins.addr[COL_W-1:0]});

	always @(posedge clk) begin
		if (i_reset) begin
			o_errors <= 0;
			o_writes <= 0;
			o_mode_seen <= 1'b0;
			o_dq <= 16'h0;
			bank_open <= 4'b0;
			gap <= 1000;
			min_gap <= 0;
			rd_pend <= 1'b0;
		end else begin
			gap <= gap + 1;
			rd_pend <= 1'b0;
			if (rd_pend)
				o_dq <= mem.exists(rd_addr) ? mem[rd_addr] : 16'h0;	// CAS latency 2.
			if (i_pins.cmd != NOP) begin
				gap <= 1;
				if (gap < min_gap) begin
					o_errors <= o_errors + 1;
					$display("%s issued %0d cycles after the previous command, needs %0d",
						i_pins.cmd.name(), gap, min_gap);
				end
				case (i_pins.cmd)
				ACTIVE: begin
					bank_open[i_pins.bank] <= 1'b1;
					open_row[i_pins.bank] <= i_pins.addr;
					min_gap <= T_RCD;
				end
				READ, WRITE: begin
					if (!bank_open[i_pins.bank]) begin
						o_errors <= o_errors + 1;
						$display("%s to bank %0d which is not active",
							i_pins.cmd.name(), i_pins.bank);
					end
					bank_open[i_pins.bank] <= 1'b0;	// Auto-precharge.
					if (i_pins.cmd == WRITE) begin
						merged = mem.exists(cur_addr) ? mem[cur_addr] : 16'h0;
						if (!i_pins.dqm[0])
							merged[7:0] = i_pins.dq_out[7:0];
						if (!i_pins.dqm[1])
							merged[15:8] = i_pins.dq_out[15:8];
						mem[cur_addr] = merged;
						o_writes <= o_writes + 1;
						min_gap <= T_RP + 1;	// Write recovery, then precharge.
					end else begin
						rd_pend <= 1'b1;
						rd_addr <= cur_addr;
						min_gap <= CAS_LATENCY + T_RP;
					end
				end
				REFRESH: min_gap <= T_RFC;
				PRECHARGE: begin
					bank_open <= 4'b0;
					min_gap <= T_RP;
				end
				MODE: begin
					o_mode_seen <= 1'b1;
					min_gap <= T_RP;
				end
				default: ;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// File: tb_sdram_port.sv
`timescale 1ns/1ns
`default_nettype none

module tb_sdram_port
	import sdram_pkg::*;
();

	localparam int TIMEOUT = 2000;
	localparam int MAX_ACCESS = 2 * (T_RCD + CAS_LATENCY + T_RP + 4);	// Two read halves.

	logic                   clk;
	logic                   reset;
	logic                   ctrl_cs;
	logic                   d_access;
	logic                   d_cs;
	logic [WORD_ADDR_W-1:0] d_addr;
	logic [31:0]            d_wr_val;
	logic                   d_wr_en;
	logic [3:0]             d_bytesel;
	logic                   i_access;
	logic                   i_cs;
	logic [WORD_ADDR_W-1:0] i_addr;
	logic [15:0]            dq_in;
	logic [15:0]            model_dq;
	logic                   d_ack;
	logic [31:0]            d_data;
	logic                   i_ack;
	logic [31:0]            i_data;
	sdram_pins_t            sdram;
	int                     model_errors;
	int                     model_writes;
	logic                   mode_seen;

	logic        d_busy;
	logic        i_busy;
	logic        d_check;
	logic        i_check;
	logic        ctrl_check;
	logic [31:0] d_exp;
	logic [31:0] i_exp;
	int          write_base;
	int          writes_exp;
	logic        write_ack_q;
	int          d_cycles;
	int          refresh_gap;
	int          refresh_count;
	int          errors;
	logic        timed_out;
	logic [31:0] shadow [int];
	int          addrs [$];

	sdram_port dut_i (
		.clk(clk), .i_reset(reset), .i_ctrl_cs(ctrl_cs),
		.i_d_access(d_access), .i_d_cs(d_cs), .i_d_addr(d_addr),
		.i_d_wr_val(d_wr_val), .i_d_wr_en(d_wr_en), .i_d_bytesel(d_bytesel),
		.i_i_access(i_access), .i_i_cs(i_cs), .i_i_addr(i_addr), .i_dq_in(dq_in),
		.o_d_ack(d_ack), .o_d_data(d_data), .o_i_ack(i_ack), .o_i_data(i_data),
		.o_sdram(sdram)
	);

	sdram_model model_i (
		.clk(clk), .i_reset(reset), .i_pins(sdram), .o_dq(model_dq),
		.o_errors(model_errors), .o_writes(model_writes), .o_mode_seen(mode_seen)
	);

	assign dq_in = sdram.dq_oe ? sdram.dq_out : model_dq;	// Pad.

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		if (reset) begin
			d_cycles <= 0;
			write_ack_q <= 1'b0;
			refresh_gap <= 0;
			refresh_count <= 0;
		end else begin
			d_cycles <= d_busy ? d_cycles + 1 : 0;
			write_ack_q <= d_ack && writes_exp != 0;
			if (sdram.cmd == REFRESH) begin
				refresh_gap <= 0;
				refresh_count <= refresh_count + 1;
			end else begin
				refresh_gap <= refresh_gap + 1;
			end
		end
	end

	assert property (@(posedge clk) disable iff (reset) d_ack && d_check |-> d_data == d_exp)
		else begin
			errors++;
			$display("Mismatch o_d_data: expected %h, got %h", $sampled(d_exp), $sampled(d_data));
		end
	assert property (@(posedge clk) disable iff (reset) i_ack && i_check |-> i_data == i_exp)
		else begin
			errors++;
			$display("Mismatch o_i_data: expected %h, got %h", $sampled(i_exp), $sampled(i_data));
		end
	assert property (@(posedge clk) disable iff (reset) d_ack && ctrl_check |-> d_cycles == 1)
		else begin
			errors++;
			$display("control register ack came %0d cycles after the request", $sampled(d_cycles));
		end
	assert property (@(posedge clk) disable iff (reset) i_busy && !d_busy |-> !d_ack)
		else begin
			errors++;
			$display("data ack came during a fetch");
		end
	assert property (@(posedge clk) disable iff (reset) i_busy && !d_busy |-> sdram.cmd != WRITE)
		else begin
			errors++;
			$display("WRITE command issued during a fetch");
		end
	assert property (@(posedge clk) disable iff (reset) i_ack |-> !d_busy)
		else begin
			errors++;
			$display("instruction ack came before the data ack");
		end
	assert property (@(posedge clk) disable iff (reset)
		write_ack_q |-> model_writes - write_base == writes_exp)
		else begin
			errors++;
			$display("Mismatch WRITE count: expected %h, got %h", $sampled(writes_exp),
				$sampled(model_writes - write_base));
		end
	assert property (@(posedge clk) disable iff (reset)
		sdram.cmd == REFRESH && refresh_count > 0 |-> refresh_gap <= REFRESH_INTERVAL + MAX_ACCESS)
		else begin
			errors++;
			$display("gap of %0d cycles between REFRESH commands is too long", $sampled(refresh_gap));
		end
	assert property (@(posedge clk) disable iff (reset) sdram.cke)
		else begin
			errors++;
			$display("SDRAM clock enable went low");
		end

	function automatic logic [31:0] shadow_word(input int a);
		return shadow.exists(a) ? shadow[a] : 32'h0;
	endfunction

	task automatic report_timeout(input string what);
		errors++;
		timed_out = 1'b1;
		$display("timeout waiting for %s", what);
	endtask

	task automatic start_data(input int addr, input logic [31:0] wdata, input logic wr,
			input logic [3:0] mask, input logic ctrl, input logic [31:0] expect_val);
		d_access = 1'b1;
		d_cs = !ctrl;
		ctrl_cs = ctrl;
		d_addr = WORD_ADDR_W'(addr);
		d_wr_val = wdata;
		d_wr_en = wr;
		d_bytesel = mask;
		d_busy = 1'b1;
		d_check = !wr;
		d_exp = expect_val;
		ctrl_check = ctrl;
		write_base = model_writes;
		writes_exp = wr ? int'(|mask[3:2]) + int'(|mask[1:0]) : 0;
	endtask

	task automatic start_fetch(input int addr);
		i_access = 1'b1;
		i_cs = 1'b1;
		i_addr = WORD_ADDR_W'(addr);
		i_busy = 1'b1;
		i_check = 1'b1;
		i_exp = shadow_word(addr);
	endtask

	// Drops each request 2 ns after its ack, then idles one cycle.
	task automatic wait_acks(input logic want_d, input logic want_i);
		int   n;
		logic got_d;
		logic got_i;
		logic saw_d;
		logic saw_i;
		n = 0;
		got_d = !want_d;
		got_i = !want_i;
		while (!(got_d && got_i) && n < TIMEOUT && !timed_out) begin
			@(posedge clk);
			saw_d = d_ack;
			saw_i = i_ack;
			n++;
			#2;
			if (saw_d && !got_d) begin
				got_d = 1'b1;
				d_access = 1'b0;
				d_cs = 1'b0;
				ctrl_cs = 1'b0;
				d_wr_en = 1'b0;
				d_busy = 1'b0;
				d_check = 1'b0;
				ctrl_check = 1'b0;
			end
			if (saw_i && !got_i) begin
				got_i = 1'b1;
				i_access = 1'b0;
				i_cs = 1'b0;
				i_busy = 1'b0;
				i_check = 1'b0;
			end
		end
		if (!(got_d && got_i) && !timed_out)
			report_timeout("a bus ack");
		@(posedge clk);
	endtask

	task automatic write_word(input int addr, input logic [31:0] data, input logic [3:0] mask);
		logic [31:0] word;
		@(posedge clk);
		#2;
		start_data(addr, data, 1'b1, mask, 1'b0, 32'h0);
		wait_acks(1'b1, 1'b0);
		word = shadow_word(addr);
		for (int b = 0; b < 4; b++)
			if (mask[b])
				word[8*b +: 8] = data[8*b +: 8];
		shadow[addr] = word;
	endtask

	task automatic read_word(input int addr);
		@(posedge clk);
		#2;
		start_data(addr, 32'h0, 1'b0, 4'hf, 1'b0, shadow_word(addr));
		wait_acks(1'b1, 1'b0);
	endtask

	task automatic read_ctrl(input logic [31:0] expect_val);
		@(posedge clk);
		#2;
		start_data(0, 32'h0, 1'b0, 4'hf, 1'b1, expect_val);
		wait_acks(1'b1, 1'b0);
	endtask

	task automatic fetch_word(input int addr);
		@(posedge clk);
		#2;
		d_wr_en = 1'b1;	// Idle data bus lines that a fetch must ignore.
		d_bytesel = 4'b0000;
		start_fetch(addr);
		wait_acks(1'b0, 1'b1);
	endtask

	task automatic read_and_fetch(input int d_a, input int i_a);
		@(posedge clk);
		#2;
		start_data(d_a, 32'h0, 1'b0, 4'hf, 1'b0, shadow_word(d_a));
		start_fetch(i_a);
		wait_acks(1'b1, 1'b1);
	endtask

	initial begin
		int          a;
		int          n;
		logic [3:0]  mask;
		logic [31:0] data;
		void'($urandom(69));
		reset = 1'b1;
		ctrl_cs = 1'b0;
		d_access = 1'b0;
		d_cs = 1'b0;
		d_addr = '0;
		d_wr_val = 32'h0;
		d_wr_en = 1'b0;
		d_bytesel = 4'h0;
		i_access = 1'b0;
		i_cs = 1'b0;
		i_addr = '0;
		d_busy = 1'b0;
		i_busy = 1'b0;
		d_check = 1'b0;
		i_check = 1'b0;
		ctrl_check = 1'b0;
		d_exp = 32'h0;
		i_exp = 32'h0;
		write_base = 0;
		writes_exp = 0;
		errors = 0;
		timed_out = 1'b0;
		repeat (5) @(posedge clk);
		#2;
		reset = 1'b0;

		read_ctrl(32'h0);
		n = 0;
		while (!mode_seen && n < TIMEOUT) begin
			@(posedge clk);
			n++;
		end
		if (!mode_seen)
			report_timeout("the MODE command");
		repeat (T_RP + 2) @(posedge clk);
		read_ctrl(32'h1);

		repeat (16) begin
			a = int'($urandom) & ((1 << WORD_ADDR_W) - 1);
			write_word(a, $urandom, 4'hf);
			addrs.push_back(a);
		end
		for (int k = 0; k < 16; k++) begin
			a = addrs[$urandom % addrs.size()];
			data = $urandom;
			case (k)
			0: mask = 4'b0011;
			1: mask = 4'b1100;
			2: mask = 4'b0000;
			3: mask = 4'b1111;
			default: mask = 4'($urandom);
			endcase
			write_word(a, data, mask);
		end
		repeat (3)
			foreach (addrs[k])
				read_word(addrs[k]);
		for (int k = 0; k < 8; k++)
			fetch_word(addrs[k]);
		for (int k = 0; k < 4; k++)
			read_and_fetch(addrs[k], addrs[k + 4]);

		assert (refresh_count >= 4)
			else begin
				errors++;
				$display("only %0d REFRESH commands were seen", refresh_count);
			end
		$display("errors: %0d testbench, %0d model", errors, model_errors);
		if (errors == 0 && model_errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: sources.f
sdram_pkg.sv
sdram_arbiter.sv
bridge_32_16.sv
sdram_controller.sv
sdram_port.sv
sdram_model.sv
tb_sdram_port.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_sdram_port
RTL_TOP ?= sdram_port
FILELIST ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0
RTL_FILES ?= sdram_pkg.sv sdram_arbiter.sv bridge_32_16.sv sdram_controller.sv sdram_port.sv

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep "all tests passed" > /dev/null

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(RTL_TOP) $(RTL_FILES)

clean:
	rm -rf $(BUILD_DIR)
